// File: Bender.yml
package:
  name: z80_bridge

sources:
  - design/z80_bridge_pkg.sv
  - design/z80_bus_sync.sv
  - design/z80_cmd_filter.sv
  - design/z80_mem_window.sv
  - design/z80_io_ports.sv
  - design/z80_read_driver.sv
  - design/z80_bridge.sv
  - target: test
    files:
      - tests/z80_bridge_asserts.sv
      - tests/z80_bridge_tb.sv

// File: design/z80_bridge.sv
`timescale 1ns/1ps

module z80_bridge #(
   parameter int          USE_Z80_CLK    = 1,
   parameter int          INV_Z80_CLK    = 0,
   parameter int          CLK_FILTER     = 0,        // Memory command filter
   parameter int          CLK_FILTER_P   = 2,        // Port command filter
   parameter logic [2:0]  MEMORY_RANGE   = 3'b010,
   parameter int          MEM_SIZE_BYTES = 40960,
   parameter int          BANK_RESPONSE  = 1,
   parameter logic [14:0] BANK_ID_ADDR   = '1
) (
   input  logic                                   GPU_CLK,
   input  logic                                   rst_n,
   input  logic                                   Z80_CLK,
   input  logic                                   Z80_M1n,
   input  logic                                   Z80_MREQn,
   input  logic                                   Z80_IORQn,
   input  logic                                   Z80_RDn,
   input  logic                                   Z80_WRn,
   input  logic [z80_bridge_pkg::Z80_ADDR_W-1:0]  Z80_addr,
   input  logic [z80_bridge_pkg::DATA_W-1:0]      Z80_wData,
   input  logic                                   PS2_RDY,
   input  logic [z80_bridge_pkg::DATA_W-1:0]      PS2_DAT,
   input  logic [z80_bridge_pkg::DATA_W-1:0]      gpu_rData,
   input  logic                                   gpu_rd_rdy,
   output logic [z80_bridge_pkg::DATA_W-1:0]      Z80_rData,
   output logic                                   Z80_rData_ena,
   output logic                                   Z80_245data_dir,
   output logic [z80_bridge_pkg::GPU_ADDR_W-1:0]  gpu_addr,
   output logic [z80_bridge_pkg::DATA_W-1:0]      gpu_wdata,
   output logic                                   gpu_wr_ena,
   output logic                                   gpu_rd_req,
   output logic                                   SPKR_EN,
   output logic                                   VIDEO_EN
);

   logic m1_n, mreq_n, iorq_n, rd_n, wr_n, zclk;     // Registered bus controls
   logic [z80_bridge_pkg::Z80_ADDR_W-1:0] addr;
   logic [z80_bridge_pkg::DATA_W-1:0]     wdata, mem_rdata, port_rdata;
   logic                                  mem_rvalid, port_rvalid, cmd_start;
   z80_bridge_pkg::z80_cmd_e              cmd;

   z80_bus_sync #(.USE_Z80_CLK(USE_Z80_CLK), .INV_Z80_CLK(INV_Z80_CLK)) u_bus_sync (
      .GPU_CLK, .rst_n, .Z80_CLK, .Z80_M1n, .Z80_MREQn, .Z80_IORQn, .Z80_RDn, .Z80_WRn,
      .Z80_addr, .Z80_wData, .m1_n, .mreq_n, .iorq_n, .rd_n, .wr_n, .addr, .wdata, .zclk
   );

   z80_cmd_filter #(.CLK_FILTER(CLK_FILTER), .CLK_FILTER_P(CLK_FILTER_P)) u_cmd_filter (
      .GPU_CLK, .rst_n, .m1_n, .mreq_n, .iorq_n, .rd_n, .wr_n, .zclk, .cmd, .cmd_start
   );

   z80_mem_window #(
      .MEMORY_RANGE(MEMORY_RANGE), .MEM_SIZE_BYTES(MEM_SIZE_BYTES),
      .BANK_RESPONSE(BANK_RESPONSE), .BANK_ID_ADDR(BANK_ID_ADDR)
   ) u_mem_window (
      .GPU_CLK, .rst_n, .cmd, .cmd_start, .addr, .wdata, .rd_n, .gpu_rData, .gpu_rd_rdy,
      .gpu_addr, .gpu_wdata, .gpu_wr_ena, .gpu_rd_req, .mem_rdata, .mem_rvalid
   );

   z80_io_ports u_io_ports (
      .GPU_CLK, .rst_n, .cmd, .cmd_start,
      .addr       (addr[7:0]),                       // Port number only
      .wdata, .PS2_RDY, .PS2_DAT, .SPKR_EN, .VIDEO_EN, .port_rdata, .port_rvalid
   );

   z80_read_driver u_read_driver (
      .GPU_CLK, .rst_n, .rd_n, .mem_rdata, .mem_rvalid, .port_rdata, .port_rvalid,
      .Z80_rData, .Z80_rData_ena, .Z80_245data_dir
   );

endmodule

// File: design/z80_bridge_pkg.sv
package z80_bridge_pkg;

   // **************************************************
   // Bus widths
   // **************************************************
   localparam int Z80_ADDR_W = 22;                   // Host address bus
   localparam int GPU_ADDR_W = 20;                   // GPU RAM address
   localparam int DATA_W     = 8;                    // Both data buses

   // Decoded Z80 bus command
   typedef enum logic [2:0] {
      CMD_IDLE,                                      // No accepted command
      CMD_READ_MEM,
      CMD_WRITE_MEM,
      CMD_READ_PORT,
      CMD_WRITE_PORT
   } z80_cmd_e;

   // IO port map, low 8 bits of the address
   typedef enum logic [7:0] {
      PORT_KEY_DATA = 8'd240,                        // Keyboard character
      PORT_KEY_STAT = 8'd241,                        // Keyboard status
      PORT_SPKR     = 8'd242,                        // Speaker enable
      PORT_BLNK     = 8'd243                         // Video enable (DAC blank)
   } z80_port_e;

   // Level converter direction
   localparam logic DIR_TO_GPU = 1'b0;               // Z80 drives the data bus
   localparam logic DIR_TO_Z80 = 1'b1;               // Bridge drives the data bus

   // Bank ID bytes, indexed by the low 4 address bits
   localparam logic [DATA_W-1:0] BANK_ID [16] = '{
      8'd9,   8'd3,  8'd71, 8'd80,
      8'd85,  8'd32, 8'd69, 8'd80,
      8'd52,  8'd67, 8'd69, 8'd49,
      8'd48,  8'd0,  8'd255, 8'd255
   };

endpackage

// File: design/z80_bus_sync.sv
`timescale 1ns/1ps

module z80_bus_sync #(
   parameter int USE_Z80_CLK = 1,                    // 0 makes every cycle a bus cycle
   parameter int INV_Z80_CLK = 0                     // Invert Z80_CLK before edge detect
) (
   input  logic                                   GPU_CLK,
   input  logic                                   rst_n,
   input  logic                                   Z80_CLK,
   input  logic                                   Z80_M1n,
   input  logic                                   Z80_MREQn,
   input  logic                                   Z80_IORQn,
   input  logic                                   Z80_RDn,
   input  logic                                   Z80_WRn,
   input  logic [z80_bridge_pkg::Z80_ADDR_W-1:0]  Z80_addr,
   input  logic [z80_bridge_pkg::DATA_W-1:0]      Z80_wData,
   output logic                                   m1_n,
   output logic                                   mreq_n,
   output logic                                   iorq_n,
   output logic                                   rd_n,
   output logic                                   wr_n,
   output logic [z80_bridge_pkg::Z80_ADDR_W-1:0]  addr,
   output logic [z80_bridge_pkg::DATA_W-1:0]      wdata,
   output logic                                   zclk
);

   logic zclk_s1, zclk_s2;                           // Z80_CLK sampling stages
   logic edge_r;                                     // Registered edge strobe

   // **************************************************
   // Control lines, idle high out of reset
   // **************************************************
   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         m1_n   <= 1'b1;
         mreq_n <= 1'b1;
         iorq_n <= 1'b1;
         rd_n   <= 1'b1;
         wr_n   <= 1'b1;
      end else begin
         m1_n   <= Z80_M1n;
         mreq_n <= Z80_MREQn;
         iorq_n <= Z80_IORQn;
         rd_n   <= Z80_RDn;
         wr_n   <= Z80_WRn;
      end
   end

   always_ff @(posedge GPU_CLK) begin
      addr  <= Z80_addr;                             // Address and data are plain payload
      wdata <= Z80_wData;
   end

   // Clock edge detect, either transition counts
   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         zclk_s1 <= 1'b0;
         zclk_s2 <= 1'b0;
         edge_r  <= 1'b0;
      end else begin
         zclk_s1 <= Z80_CLK ^ (INV_Z80_CLK != 0);    // Optional polarity flip
         zclk_s2 <= zclk_s1;
         edge_r  <= zclk_s1 ^ zclk_s2;               // Stages differ right after a transition
      end
   end

   assign zclk = (USE_Z80_CLK == 0) || edge_r;       // Free running when clock is unused

endmodule

// File: design/z80_cmd_filter.sv
`timescale 1ns/1ps

module z80_cmd_filter #(
   parameter int CLK_FILTER   = 0,                   // Memory command filter, 0..7
   parameter int CLK_FILTER_P = 2                    // Port command filter, 0..7
) (
   input  logic                      GPU_CLK,
   input  logic                      rst_n,
   input  logic                      m1_n,
   input  logic                      mreq_n,
   input  logic                      iorq_n,
   input  logic                      rd_n,
   input  logic                      wr_n,
   input  logic                      zclk,
   output z80_bridge_pkg::z80_cmd_e  cmd,
   output logic                      cmd_start
);

   // Command index 0 read mem, 1 write mem, 2 read port, 3 write port
   logic [3:0] op_dec;                               // Raw decode of bus levels
   logic [3:0] hit;                                  // Filter limit reached on a strobe
   logic [2:0] fc [4];                               // Filter counters
   z80_bridge_pkg::z80_cmd_e last_cmd;               // For the start pulse

   // **************************************************
   // Bus level decode
   // **************************************************
   assign op_dec[0] = m1_n && iorq_n && !mreq_n && !rd_n && wr_n;
   assign op_dec[1] = m1_n && iorq_n && !mreq_n && rd_n && !wr_n;
   assign op_dec[2] = m1_n && !iorq_n && mreq_n && !rd_n && wr_n;
   assign op_dec[3] = m1_n && !iorq_n && mreq_n && rd_n && !wr_n;

   for (genvar i = 0; i < 4; i++) begin : g_filter
      localparam logic [2:0] LIMIT = (i < 2) ? 3'(CLK_FILTER) : 3'(CLK_FILTER_P);
      logic strobe_hi;                               // Strobe of this command released

      assign strobe_hi = (i % 2 == 1) ? wr_n : rd_n;

      always_ff @(posedge GPU_CLK) begin
         if (!rst_n || strobe_hi) begin
            fc[i] <= 3'd0;                           // Restart count on release
         end else if (zclk && op_dec[i] && fc[i] != LIMIT) begin
            fc[i] <= fc[i] + 3'd1;
         end
      end

      assign hit[i] = zclk && op_dec[i] && (fc[i] == LIMIT);
   end

   // **************************************************
   // Accepted command
   // **************************************************
   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         cmd      <= z80_bridge_pkg::CMD_IDLE;
         last_cmd <= z80_bridge_pkg::CMD_IDLE;
      end else begin
         last_cmd <= cmd;
         case (cmd)
            z80_bridge_pkg::CMD_READ_MEM, z80_bridge_pkg::CMD_READ_PORT: begin
               if (rd_n) cmd <= z80_bridge_pkg::CMD_IDLE;   // RD released
            end
            z80_bridge_pkg::CMD_WRITE_MEM, z80_bridge_pkg::CMD_WRITE_PORT: begin
               if (wr_n) cmd <= z80_bridge_pkg::CMD_IDLE;   // WR released
            end
            default: begin
               if (hit[0])      cmd <= z80_bridge_pkg::CMD_READ_MEM;
               else if (hit[1]) cmd <= z80_bridge_pkg::CMD_WRITE_MEM;
               else if (hit[2]) cmd <= z80_bridge_pkg::CMD_READ_PORT;
               else if (hit[3]) cmd <= z80_bridge_pkg::CMD_WRITE_PORT;
            end
         endcase
      end
   end

   // First cycle of a new command
   assign cmd_start = (cmd != z80_bridge_pkg::CMD_IDLE) && (cmd != last_cmd);

endmodule

// File: design/z80_io_ports.sv
`timescale 1ns/1ps

module z80_io_ports (
   input  logic                               GPU_CLK,
   input  logic                               rst_n,
   input  z80_bridge_pkg::z80_cmd_e           cmd,
   input  logic                               cmd_start,
   input  logic [7:0]                         addr,      // Port number
   input  logic [z80_bridge_pkg::DATA_W-1:0]  wdata,
   input  logic                               PS2_RDY,
   input  logic [z80_bridge_pkg::DATA_W-1:0]  PS2_DAT,
   output logic                               SPKR_EN,
   output logic                               VIDEO_EN,
   output logic [z80_bridge_pkg::DATA_W-1:0]  port_rdata,
   output logic                               port_rvalid
);

   logic [7:0]                        rdy_hist;      // PS2_RDY history
   logic [z80_bridge_pkg::DATA_W-1:0] key_char;      // Last keyboard character
   logic [z80_bridge_pkg::DATA_W-1:0] key_stat;      // Status read counter
   logic rd_go, wr_go, port_hit;

   assign rd_go    = cmd_start && (cmd == z80_bridge_pkg::CMD_READ_PORT);
   assign wr_go    = cmd_start && (cmd == z80_bridge_pkg::CMD_WRITE_PORT);
   assign port_hit = (addr >= z80_bridge_pkg::PORT_KEY_DATA) &&
                     (addr <= z80_bridge_pkg::PORT_BLNK);    // Ports 240..243

   // **************************************************
   // Keyboard and control registers
   // **************************************************
   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         rdy_hist <= '0;
         key_char <= '0;
         key_stat <= '0;
         SPKR_EN  <= 1'b0;
         VIDEO_EN <= 1'b1;                           // Video on out of reset
         port_rvalid <= 1'b0;
      end else begin
         rdy_hist <= {rdy_hist[6:0], PS2_RDY};
         if (rd_go && addr == z80_bridge_pkg::PORT_KEY_DATA) key_char <= '0;  // Clear on read
         if (rdy_hist == 8'b0000_1111) key_char <= PS2_DAT;    // Ready settled high
         if (rd_go && addr == z80_bridge_pkg::PORT_KEY_STAT) key_stat <= key_stat + 8'd1;
         if (wr_go && addr == z80_bridge_pkg::PORT_SPKR) SPKR_EN  <= wdata[0];
         if (wr_go && addr == z80_bridge_pkg::PORT_BLNK) VIDEO_EN <= wdata[0];
         port_rvalid <= (cmd == z80_bridge_pkg::CMD_READ_PORT) && port_hit;  // Aligned with data
      end
   end

   // Read data captured at the read start
   always_ff @(posedge GPU_CLK) begin
      if (rd_go) begin
         case (addr)
            z80_bridge_pkg::PORT_KEY_DATA: port_rdata <= key_char;
            z80_bridge_pkg::PORT_KEY_STAT: port_rdata <= key_stat;
            z80_bridge_pkg::PORT_SPKR:     port_rdata <= {7'd0, SPKR_EN};
            z80_bridge_pkg::PORT_BLNK:     port_rdata <= {7'd0, VIDEO_EN};
            default:                       port_rdata <= '0;
         endcase
      end
   end

endmodule

// File: design/z80_mem_window.sv
`timescale 1ns/1ps

module z80_mem_window #(
   parameter logic [2:0]  MEMORY_RANGE   = 3'b010,   // addr[21:19] selecting the 512 KB window
   parameter int          MEM_SIZE_BYTES = 40960,    // GPU RAM size, above reads 0xFF
   parameter int          BANK_RESPONSE  = 1,        // Answer bank ID reads
   parameter logic [14:0] BANK_ID_ADDR   = '1        // addr[18:4] of the bank ID block
) (
   input  logic                                   GPU_CLK,
   input  logic                                   rst_n,
   input  z80_bridge_pkg::z80_cmd_e               cmd,
   input  logic                                   cmd_start,
   input  logic [z80_bridge_pkg::Z80_ADDR_W-1:0]  addr,
   input  logic [z80_bridge_pkg::DATA_W-1:0]      wdata,
   input  logic                                   rd_n,
   input  logic [z80_bridge_pkg::DATA_W-1:0]      gpu_rData,
   input  logic                                   gpu_rd_rdy,
   output logic [z80_bridge_pkg::GPU_ADDR_W-1:0]  gpu_addr,
   output logic [z80_bridge_pkg::DATA_W-1:0]      gpu_wdata,
   output logic                                   gpu_wr_ena,
   output logic                                   gpu_rd_req,
   output logic [z80_bridge_pkg::DATA_W-1:0]      mem_rdata,
   output logic                                   mem_rvalid
);

   localparam logic [19:0] MEM_LIMIT = 20'(MEM_SIZE_BYTES);

   logic in_bank, in_range, in_id;                   // Window decode
   logic wr_go, rd_go;                               // Start of a RAM access
   logic rd_pend;                                    // Waiting for gpu_rd_rdy

   assign in_bank  = (addr[21:19] == MEMORY_RANGE);
   assign in_range = in_bank && ({1'b0, addr[18:0]} < MEM_LIMIT);
   assign in_id    = in_bank && (addr[18:4] == BANK_ID_ADDR);

   assign wr_go = cmd_start && (cmd == z80_bridge_pkg::CMD_WRITE_MEM) && in_range;
   assign rd_go = cmd_start && (cmd == z80_bridge_pkg::CMD_READ_MEM) && in_range;

   // **************************************************
   // GPU RAM requests
   // **************************************************
   always_ff @(posedge GPU_CLK) begin
      if (!rst_n) begin
         gpu_wr_ena <= 1'b0;
         gpu_rd_req <= 1'b0;
         rd_pend    <= 1'b0;
      end else begin
         gpu_wr_ena <= wr_go;                        // One cycle pulses
         gpu_rd_req <= rd_go;
         if (rd_go)                   rd_pend <= 1'b1;
         else if (gpu_rd_rdy || rd_n) rd_pend <= 1'b0;  // Late ready is dropped
      end
   end

   always_ff @(posedge GPU_CLK) begin
      if (wr_go || rd_go) gpu_addr <= addr[19:0];
      if (wr_go)          gpu_wdata <= wdata;
   end

   // Read answer, RAM data or the out of range filler
   always_comb begin
      if (rd_pend && gpu_rd_rdy)
         mem_rdata = gpu_rData;
      else if (BANK_RESPONSE != 0 && in_id)
         mem_rdata = z80_bridge_pkg::BANK_ID[addr[3:0]];
      else
         mem_rdata = 8'hFF;
   end

   assign mem_rvalid = (rd_pend && gpu_rd_rdy) ||
                       ((cmd == z80_bridge_pkg::CMD_READ_MEM) && in_bank && !in_range);

endmodule

// File: design/z80_read_driver.sv
`timescale 1ns/1ps

module z80_read_driver (
   input  logic                               GPU_CLK,
   input  logic                               rst_n,
   input  logic                               rd_n,
   input  logic [z80_bridge_pkg::DATA_W-1:0]  mem_rdata,
   input  logic                               mem_rvalid,
   input  logic [z80_bridge_pkg::DATA_W-1:0]  port_rdata,
   input  logic                               port_rvalid,
   output logic [z80_bridge_pkg::DATA_W-1:0]  Z80_rData,
   output logic                               Z80_rData_ena,
   output logic                               Z80_245data_dir
);

   // **************************************************
   // Data bus drive, held until RD goes away
   // **************************************************
   always_ff @(posedge GPU_CLK) begin
      if (!rst_n || rd_n) begin                      // Idle, converter back toward GPU
         Z80_rData       <= '0;
         Z80_rData_ena   <= 1'b0;
         Z80_245data_dir <= z80_bridge_pkg::DIR_TO_GPU;
      end else if (!Z80_rData_ena && (mem_rvalid || port_rvalid)) begin
         Z80_rData       <= mem_rvalid ? mem_rdata : port_rdata;  // First answer wins
         Z80_rData_ena   <= 1'b1;
         Z80_245data_dir <= z80_bridge_pkg::DIR_TO_Z80;
      end
   end

endmodule

// File: list.f
design/z80_bridge_pkg.sv
design/z80_bus_sync.sv
design/z80_cmd_filter.sv
design/z80_mem_window.sv
design/z80_io_ports.sv
design/z80_read_driver.sv
design/z80_bridge.sv
tests/z80_bridge_asserts.sv
tests/z80_bridge_tb.sv

// File: tests/z80_bridge_asserts.sv
`timescale 1ns/1ps

module z80_bridge_asserts (
   input logic GPU_CLK,
   input logic rst_n,
   input logic gpu_wr_ena,
   input logic gpu_rd_req,
   input logic Z80_rData_ena,
   input logic Z80_245data_dir
);

   int fail_count = 0;                               // Failed assertion count

   // **************************************************
   // GPU RAM strobes
   // **************************************************
   a_wr_pulse: assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      gpu_wr_ena |=> !gpu_wr_ena)
      else begin
         fail_count++;
         $error("gpu_wr_ena held longer than one cycle");
      end

   a_rd_pulse: assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      gpu_rd_req |=> !gpu_rd_req)
      else begin
         fail_count++;
         $error("gpu_rd_req held longer than one cycle");
      end

   a_no_overlap: assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      !(gpu_wr_ena && gpu_rd_req))
      else begin
         fail_count++;
         $error("gpu_wr_ena and gpu_rd_req together");
      end

   // Data drive needs the converter pointed at the Z80
   a_dir: assert property (@(posedge GPU_CLK) disable iff (!rst_n)
      Z80_rData_ena |-> (Z80_245data_dir == z80_bridge_pkg::DIR_TO_Z80))
      else begin
         fail_count++;
         $error("Z80_rData_ena without DIR_TO_Z80");
      end

   a_reset: assert property (@(posedge GPU_CLK)
      !rst_n |=> (!gpu_wr_ena && !gpu_rd_req && !Z80_rData_ena))
      else begin
         fail_count++;
         $error("Strobe active after a reset cycle");
      end

endmodule

bind z80_bridge z80_bridge_asserts u_asserts (
   .GPU_CLK, .rst_n, .gpu_wr_ena, .gpu_rd_req, .Z80_rData_ena, .Z80_245data_dir
);

// File: tests/z80_bridge_tb.sv
`timescale 1ns/1ps

module z80_bridge_tb;

   localparam logic [31:0] LFSR_SEED = 32'hc851ae6b;
   localparam logic [2:0]  MEM_BANK  = 3'b010;       // Default window in addr[21:19]
   localparam int          MEM_SIZE  = 40960;        // Default GPU RAM size

   logic GPU_CLK, rst_n, Z80_CLK, Z80_M1n, Z80_MREQn, Z80_IORQn, Z80_RDn, Z80_WRn;
   logic PS2_RDY, gpu_rd_rdy, Z80_rData_ena, Z80_245data_dir, gpu_wr_ena, gpu_rd_req;
   logic SPKR_EN, VIDEO_EN;
   logic [21:0] Z80_addr;
   logic [19:0] gpu_addr;
   logic [7:0]  Z80_wData, PS2_DAT, gpu_rData, Z80_rData, gpu_wdata;

   logic [7:0]  ram [65536];                         // GPU RAM model
   logic [7:0]  exp_ram [65536];                     // Expected RAM contents
   logic [27:0] exp_wr [$];                          // Expected writes as addr and data
   logic [19:0] exp_rq [$];                          // Expected read request addresses
   logic [7:0]  exp_rd [$];                          // Expected Z80 read bytes
   logic [7:0]  key_exp, stat_exp;                   // Keyboard model state
   logic        spkr_exp, video_exp, ena_q;
   logic [31:0] seq_lfsr, gpu_lfsr;                  // Stimulus and GPU delay streams
   logic [27:0] cmp_wr;
   logic [7:0]  cmp_rd;
   logic [15:0] rd_addr;
   int          rd_wait, zdiv, value_errs, other_errs;

   z80_bridge u_z80_bridge (.*);

   always #50 GPU_CLK = ~GPU_CLK;                    // 100 ns period

   always @(negedge GPU_CLK) begin                   // Z80_CLK toggles every 4 cycles
      zdiv = (zdiv + 1) % 4;
      if (zdiv == 0) Z80_CLK = ~Z80_CLK;
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(inout logic [31:0] st, input int n);
      logic [31:0] r;
      int i;
      r = '0;
      for (i = 0; i < n; i++) begin
         r  = {r[30:0], st[0]};
         st = st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
      end
      return r;
   endfunction

   function automatic logic in_ram(input logic [21:0] a);
      return (a[21:19] == MEM_BANK) && (a[18:0] < MEM_SIZE);
   endfunction

   // Reference model where bit 8 says whether the read answers
   function automatic logic [8:0] predict_read(input logic is_port, input logic [21:0] a);
      if (is_port) begin
         case (a[7:0])
            8'd240:  return {1'b1, key_exp};
            8'd241:  return {1'b1, stat_exp};
            8'd242:  return {1'b1, 7'd0, spkr_exp};
            8'd243:  return {1'b1, 7'd0, video_exp};
            default: return 9'h000;
         endcase
      end
      if (a[21:19] != MEM_BANK) return 9'h000;   // Outside the window stays silent
      if (a[18:0] < MEM_SIZE) return {1'b1, exp_ram[a[15:0]]};
      if (a[18:4] == 15'h7fff) return {1'b1, z80_bridge_pkg::BANK_ID[a[3:0]]};
      return 9'h1ff;                                 // Filler past the RAM
   endfunction

   task automatic log_mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
      value_errs++;
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
   endtask

   task automatic count_failure(input string what);
      other_errs++;
      $display("Failure at %0t ns: %s", $time, what);
   endtask

   // **************************************************
   // GPU RAM model answering after 1 to 8 cycles
   // **************************************************
   always @(negedge GPU_CLK) begin
      gpu_rd_rdy = 1'b0;
      if (gpu_wr_ena) ram[gpu_addr[15:0]] = gpu_wdata;
      if (rd_wait > 0) begin
         rd_wait--;
         if (rd_wait == 0) begin
            gpu_rd_rdy = 1'b1;
            gpu_rData  = ram[rd_addr];
         end
      end else if (gpu_rd_req) begin
         rd_wait = 1 + int'(rand_bits(gpu_lfsr, 3));
         rd_addr = gpu_addr[15:0];
      end
   end

   // **************************************************
   // Compare process
   // **************************************************
   always @(negedge GPU_CLK) begin
      if (rst_n) begin
         if (gpu_wr_ena) begin
            assert (exp_wr.size() != 0) else count_failure("gpu_wr_ena with no write expected");
            if (exp_wr.size() != 0) begin
               cmp_wr = exp_wr.pop_front();
               assert (gpu_addr == cmp_wr[27:8])
                  else log_mismatch("gpu_addr", gpu_addr, cmp_wr[27:8]);
               assert (gpu_wdata == cmp_wr[7:0])
                  else log_mismatch("gpu_wdata", gpu_wdata, cmp_wr[7:0]);
            end
         end
         if (gpu_rd_req) begin
            assert (exp_rq.size() != 0) else count_failure("gpu_rd_req with no read expected");
            if (exp_rq.size() != 0) begin
               assert (gpu_addr == exp_rq[0]) else log_mismatch("gpu_addr", gpu_addr, exp_rq[0]);
               void'(exp_rq.pop_front());
            end
         end
         if (Z80_rData_ena && !ena_q) begin     // New read answer on the bus
            assert (exp_rd.size() != 0) else count_failure("Z80_rData_ena with no answer expected");
            if (exp_rd.size() != 0) begin
               cmp_rd = exp_rd.pop_front();
               assert (Z80_rData == cmp_rd) else log_mismatch("Z80_rData", Z80_rData, cmp_rd);
            end
            assert (Z80_245data_dir == z80_bridge_pkg::DIR_TO_Z80)
               else log_mismatch("Z80_245data_dir", Z80_245data_dir, z80_bridge_pkg::DIR_TO_Z80);
         end
      end
      ena_q = Z80_rData_ena;
   end

   // One Z80 bus cycle with controls held for 40 GPU cycles
   task automatic bus_cycle(input logic is_port, input logic is_write,
                            input logic [21:0] a, input logic [7:0] d);
      logic [8:0] pred;
      logic seen;
      int i;
      pred = 9'h000;
      seen = 1'b0;
      if (!is_write) pred = predict_read(is_port, a);
      if (pred[8]) exp_rd.push_back(pred[7:0]);
      if (!is_port && !is_write && in_ram(a)) exp_rq.push_back(a[19:0]);
      if (!is_port && is_write && in_ram(a)) begin
         exp_wr.push_back({a[19:0], d});
         exp_ram[a[15:0]] = d;
      end
      if (is_port && is_write && a[7:0] == 8'd242) spkr_exp = d[0];
      if (is_port && is_write && a[7:0] == 8'd243) video_exp = d[0];
      if (is_port && !is_write && a[7:0] == 8'd240) key_exp = 8'd0;    // Cleared by the read
      if (is_port && !is_write && a[7:0] == 8'd241) stat_exp++;
      Z80_addr  = a;
      Z80_wData = d;
      Z80_MREQn = is_port;
      Z80_IORQn = !is_port;
      Z80_RDn   = is_write;
      Z80_WRn   = !is_write;
      for (i = 0; i < 40; i++) begin
         @(negedge GPU_CLK);
         if (Z80_rData_ena) seen = 1'b1;
      end
      assert (!pred[8] || seen) else count_failure("timed out waiting for Z80_rData_ena");
      Z80_MREQn = 1'b1;
      Z80_IORQn = 1'b1;
      Z80_RDn   = 1'b1;
      Z80_WRn   = 1'b1;
      i = 0;
      while ((Z80_rData_ena || Z80_245data_dir != z80_bridge_pkg::DIR_TO_GPU) && i < 4) begin
         @(negedge GPU_CLK);
         i++;
      end
      assert (!Z80_rData_ena && Z80_245data_dir == z80_bridge_pkg::DIR_TO_GPU)
         else count_failure("read drive not released within 4 cycles of RD high");
      if (is_port && is_write) begin
         assert (SPKR_EN == spkr_exp) else log_mismatch("SPKR_EN", SPKR_EN, spkr_exp);
         assert (VIDEO_EN == video_exp) else log_mismatch("VIDEO_EN", VIDEO_EN, video_exp);
      end
      for (i = 0; i < 4; i++) @(negedge GPU_CLK);   // Bus idle gap
   endtask

   initial begin
      logic [21:0] wr_addr [6];
      logic [7:0]  k;
      int n, total;
      GPU_CLK = 1'b0;
      rst_n = 1'b0;
      Z80_CLK = 1'b0;
      Z80_M1n = 1'b1;
      Z80_MREQn = 1'b1;
      Z80_IORQn = 1'b1;
      Z80_RDn = 1'b1;
      Z80_WRn = 1'b1;
      Z80_addr = '0;
      Z80_wData = '0;
      PS2_RDY = 1'b0;
      PS2_DAT = '0;
      gpu_rData = '0;
      gpu_rd_rdy = 1'b0;
      seq_lfsr = LFSR_SEED;
      gpu_lfsr = LFSR_SEED;
      key_exp = 8'd0;
      stat_exp = 8'd0;
      spkr_exp = 1'b0;
      video_exp = 1'b1;
      ena_q = 1'b0;
      rd_wait = 0;
      zdiv = 0;
      value_errs = 0;
      other_errs = 0;
      for (n = 0; n < 65536; n++) begin              // Fill follows all 16 index bits
         ram[n]     = 8'(n) ^ 8'(n >> 8) ^ 8'h5a;
         exp_ram[n] = ram[n];
      end
      repeat (3) @(negedge GPU_CLK);
      rst_n = 1'b1;
      assert (VIDEO_EN == 1'b1) else log_mismatch("VIDEO_EN", VIDEO_EN, 1'b1);
      assert (SPKR_EN == 1'b0) else log_mismatch("SPKR_EN", SPKR_EN, 1'b0);
      assert (Z80_245data_dir == z80_bridge_pkg::DIR_TO_GPU)
         else log_mismatch("Z80_245data_dir", Z80_245data_dir, z80_bridge_pkg::DIR_TO_GPU);

      // **************************************************
      // Memory window
      // **************************************************
      for (n = 0; n < 6; n++) begin
         wr_addr[n] = {MEM_BANK, 3'b000, 16'(rand_bits(seq_lfsr, 16) % MEM_SIZE)};
         bus_cycle(1'b0, 1'b1, wr_addr[n], 8'(rand_bits(seq_lfsr, 8)));
      end
      bus_cycle(1'b0, 1'b1, {3'b110, 19'h00123}, 8'h33);    // Outside the bank
      bus_cycle(1'b0, 1'b1, {MEM_BANK, 19'h40000}, 8'h44);  // Past the RAM size
      for (n = 0; n < 6; n++) bus_cycle(1'b0, 1'b0, wr_addr[n], 8'h00);
      for (n = 0; n < 6; n++)
         bus_cycle(1'b0, 1'b0, {MEM_BANK, 3'b000, 16'(rand_bits(seq_lfsr, 16) % MEM_SIZE)}, 8'h00);
      bus_cycle(1'b0, 1'b0, {MEM_BANK, 19'h50000}, 8'h00);
      for (n = 0; n < 16; n += 5) bus_cycle(1'b0, 1'b0, {MEM_BANK, 15'h7fff, 4'(n)}, 8'h00);
      bus_cycle(1'b0, 1'b0, {3'b001, 19'h00040}, 8'h00);

      // Keyboard latch and status counter
      k = 8'(rand_bits(seq_lfsr, 8)) | 8'h80;
      PS2_DAT = k;
      for (n = 0; n < 6; n++) @(negedge GPU_CLK);   // Low for more than 4 cycles
      PS2_RDY = 1'b1;
      for (n = 0; n < 6; n++) @(negedge GPU_CLK);
      key_exp = k;
      bus_cycle(1'b1, 1'b0, 22'd240, 8'h00);
      bus_cycle(1'b1, 1'b0, 22'd240, 8'h00);
      for (n = 0; n < 3; n++) bus_cycle(1'b1, 1'b0, 22'd241, 8'h00);

      // Speaker and video enables
      bus_cycle(1'b1, 1'b0, 22'd243, 8'h00);
      bus_cycle(1'b1, 1'b1, 22'd242, 8'h01);
      bus_cycle(1'b1, 1'b0, 22'd242, 8'h00);
      bus_cycle(1'b1, 1'b1, 22'd243, 8'hfe);
      bus_cycle(1'b1, 1'b0, 22'd243, 8'h00);
      bus_cycle(1'b1, 1'b1, 22'd242, 8'h00);

      assert (exp_wr.size() == 0) else count_failure("expected gpu_wr_ena pulses missing");
      assert (exp_rq.size() == 0) else count_failure("expected gpu_rd_req pulses missing");
      assert (exp_rd.size() == 0) else count_failure("expected read answers missing");
      total = value_errs + other_errs + u_z80_bridge.u_asserts.fail_count;
      $display("Errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
               u_z80_bridge.u_asserts.fail_count);
      if (total == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule
